// ==== source/cache_pkg.sv ====
// direct-mapped, 16 sets of two-word blocks; addresses from F000_0000 up bypass the cache
package cache_pkg;

    // geometry
    localparam int WORD_BITS     = 32;
    localparam int BLOCK_WORDS   = 2;
    localparam int N_SETS        = 16;
    localparam int SET_BITS      = 4;
    localparam int WORD_SEL_BITS = 1;
    localparam int TAG_BITS      = WORD_BITS - SET_BITS - WORD_SEL_BITS - 2;

    localparam logic [WORD_BITS-1:0] NONCACHE_START = 32'hF000_0000;

    typedef logic [WORD_BITS-1:0]     word_t;
    typedef logic [TAG_BITS-1:0]      tag_t;
    typedef logic [SET_BITS-1:0]      set_idx_t;
    typedef logic [WORD_SEL_BITS-1:0] word_sel_t;

    // one set, 91 bits
    typedef struct packed {
        logic                        valid;
        logic                        dirty;
        tag_t                        tag;
        word_t [BLOCK_WORDS-1:0]     data;
    } frame_t;

    typedef enum logic [2:0] {
        SWEEP,      // invalidate after reset
        READY,      // hits, pass-through, miss dispatch
        WRITEBACK,  // victim block to memory
        FETCH,      // new block from memory
        FLUSH       // write back dirty frames, invalidate
    } cache_state_t;

endpackage

// ==== source/cache_sram.sv ====
// one frame per set; read data is registered and shows a same-cycle write (write-first)
`timescale 1ns/100ps

module cache_sram (
    input  logic                CLK,
    input  logic                nRST,
    input  cache_pkg::set_idx_t sel,
    input  logic                wen,
    input  cache_pkg::frame_t   wdata,
    input  cache_pkg::frame_t   wmask,  // 1 keeps the stored bit
    output cache_pkg::frame_t   rdata
);

    cache_pkg::frame_t mem [cache_pkg::N_SETS];
    cache_pkg::frame_t next_frame;

    assign next_frame = (mem[sel] & wmask) | (wdata & ~wmask);

    always_ff @(posedge CLK) begin
        if (wen) begin
            mem[sel] <= next_frame;
        end
        rdata <= wen ? next_frame : mem[sel];  // new frame visible next cycle
    end

    // a write with an unknown set would corrupt an arbitrary frame
    a_sel_known: assert property (
        @(posedge CLK) disable iff (!nRST)
        wen |-> !$isunknown(sel)
    );

endmodule

// ==== source/cache_lookup.sv ====
// combinational only; frame must be the registered read of req_set to give a valid hit
`timescale 1ns/100ps

module cache_lookup (
    input  cache_pkg::word_t     addr,
    input  cache_pkg::word_t     wdata,
    input  logic [3:0]           byte_en,
    input  cache_pkg::frame_t    frame,
    output logic                 hit,
    output logic                 noncache,
    output cache_pkg::set_idx_t  req_set,
    output cache_pkg::word_sel_t req_word,
    output cache_pkg::word_t     hit_word,
    output cache_pkg::word_t     merged_word,
    output cache_pkg::word_t     lane_word
);

    cache_pkg::tag_t req_tag;

    // tag | set | word | byte
    assign req_tag  = addr[cache_pkg::WORD_BITS-1 -: cache_pkg::TAG_BITS];
    assign req_set  = addr[cache_pkg::WORD_SEL_BITS+2 +: cache_pkg::SET_BITS];
    assign req_word = addr[2 +: cache_pkg::WORD_SEL_BITS];

    assign noncache = addr >= cache_pkg::NONCACHE_START;
    assign hit      = frame.valid && (frame.tag == req_tag) && !noncache;
    assign hit_word = frame.data[req_word];

    // per-lane merge for write hits, zero fill for pass-through writes
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            merged_word[8*i +: 8] = byte_en[i] ? wdata[8*i +: 8] : hit_word[8*i +: 8];
            lane_word[8*i +: 8]   = byte_en[i] ? wdata[8*i +: 8] : 8'h00;
        end
    end

endmodule

// ==== source/cache_counters.sv ====
// word counter wraps per block; flush index sets flush_finish after the last set until cleared
`timescale 1ns/100ps

module cache_counters (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 word_en,
    input  logic                 word_clr,
    input  logic                 flush_step_word,
    input  logic                 flush_step_set,
    input  logic                 flush_clr,
    output cache_pkg::word_sel_t word_num,
    output cache_pkg::set_idx_t  flush_set,
    output cache_pkg::word_sel_t flush_word,
    output logic                 flush_finish
);

    logic next_set;

    // leave the set on a skip or after its last word
    assign next_set = flush_step_set ||
        (flush_step_word &&
         flush_word == cache_pkg::word_sel_t'(cache_pkg::BLOCK_WORDS - 1));

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            word_num <= '0;
        end else if (word_clr) begin
            word_num <= '0;
        end else if (word_en) begin
            word_num <= word_num + 1'b1;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            flush_set    <= '0;
            flush_word   <= '0;
            flush_finish <= 1'b0;
        end else if (flush_clr) begin
            flush_set    <= '0;
            flush_word   <= '0;
            flush_finish <= 1'b0;
        end else if (next_set) begin
            flush_word <= '0;
            flush_set  <= flush_set + 1'b1;  // wraps to set 0
            if (flush_set == cache_pkg::set_idx_t'(cache_pkg::N_SETS - 1))
                flush_finish <= 1'b1;
        end else if (flush_step_word) begin
            flush_word <= flush_word + 1'b1;
        end
    end

    a_finish_after_step: assert property (
        @(posedge CLK) disable iff (!nRST)
        $rose(flush_finish) |-> $past(flush_step_word || flush_step_set)
    );

endmodule

// ==== source/cache_controller.sv ====
// processor must hold its request until busy falls; a flush waits for any pass-through in flight
`timescale 1ns/100ps

module cache_controller (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 ren,
    input  logic                 wen,
    input  logic                 flush,
    input  cache_pkg::word_t     addr,
    input  cache_pkg::word_t     wdata,
    input  logic [3:0]           byte_en,
    input  logic                 hit,
    input  logic                 noncache,
    input  cache_pkg::set_idx_t  req_set,
    input  cache_pkg::word_sel_t req_word,
    input  cache_pkg::word_t     hit_word,
    input  cache_pkg::word_t     merged_word,
    input  cache_pkg::word_t     lane_word,
    input  cache_pkg::frame_t    sram_rdata,
    input  cache_pkg::word_t     mem_rdata,
    input  logic                 mem_busy,
    input  cache_pkg::word_sel_t word_num,
    input  cache_pkg::set_idx_t  flush_set,
    input  cache_pkg::word_sel_t flush_word,
    input  logic                 flush_finish,
    output cache_pkg::set_idx_t  sram_sel,
    output logic                 sram_wen,
    output cache_pkg::frame_t    sram_wdata,
    output cache_pkg::frame_t    sram_wmask,
    output logic                 word_en,
    output logic                 word_clr,
    output logic                 flush_step_word,
    output logic                 flush_step_set,
    output logic                 flush_clr,
    output cache_pkg::word_t     mem_addr,
    output cache_pkg::word_t     mem_wdata,
    output logic                 mem_ren,
    output logic                 mem_wen,
    output logic [3:0]           mem_byte_en,
    output cache_pkg::word_t     rdata,
    output logic                 busy,
    output logic                 flush_done
);

    cache_pkg::cache_state_t state, next_state;
    logic             flush_req, go_flush;
    logic             rd_ok, rd_ok_n;       // array read matches sram_sel
    cache_pkg::word_t blk_addr, blk_addr_n; // block base for WB/FETCH
    cache_pkg::word_t xfer_addr;
    logic             req, word_last, flush_last;

    assign req        = ren || wen;
    assign word_last  = word_num == cache_pkg::word_sel_t'(cache_pkg::BLOCK_WORDS - 1);
    assign flush_last = flush_word == cache_pkg::word_sel_t'(cache_pkg::BLOCK_WORDS - 1);
    assign xfer_addr  = {blk_addr[cache_pkg::WORD_BITS-1:cache_pkg::WORD_SEL_BITS+2],
                         word_num, 2'b00};
    assign sram_sel   = (state == cache_pkg::SWEEP || state == cache_pkg::FLUSH) ?
                        flush_set : req_set;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= cache_pkg::SWEEP;
            flush_req <= 1'b0;
            rd_ok     <= 1'b0;
        end else begin
            state     <= next_state;
            flush_req <= (flush_req || flush) && !go_flush;  // hold pulse until taken
            rd_ok     <= rd_ok_n;
        end
    end

    always_ff @(posedge CLK) begin
        blk_addr <= blk_addr_n;
    end

    always_comb begin
        next_state      = state;
        go_flush        = 1'b0;
        rd_ok_n         = rd_ok;
        blk_addr_n      = blk_addr;
        sram_wen        = 1'b0;
        sram_wdata      = '0;
        sram_wmask      = '1;
        word_en         = 1'b0;
        word_clr        = 1'b0;
        flush_step_word = 1'b0;
        flush_step_set  = 1'b0;
        flush_clr       = 1'b0;
        mem_addr        = addr;
        mem_wdata       = wdata;   // bus idles with processor data
        mem_ren         = 1'b0;
        mem_wen         = 1'b0;
        mem_byte_en     = '1;      // full words for block transfers
        rdata           = hit_word;
        busy            = 1'b1;
        flush_done      = 1'b0;

        case (state)
            cache_pkg::SWEEP: begin
                sram_wen       = 1'b1;
                sram_wmask     = '0;   // zero whole frame
                flush_step_set = 1'b1;
                if (flush_finish) begin
                    flush_clr  = 1'b1;
                    next_state = cache_pkg::READY;
                end
            end
            cache_pkg::READY: begin
                if (req && noncache) begin
                    mem_ren     = ren && !wen;
                    mem_wen     = wen;
                    mem_wdata   = lane_word;
                    mem_byte_en = byte_en;
                    busy        = mem_busy;
                    rdata       = mem_rdata;
                end else if (flush || flush_req) begin
                    go_flush   = 1'b1;
                    rd_ok_n    = 1'b0;
                    next_state = cache_pkg::FLUSH;
                end else if (req && !rd_ok) begin
                    rd_ok_n = 1'b1;  // first cycle, set read in flight
                end else if (req && hit) begin
                    busy    = 1'b0;
                    rd_ok_n = 1'b0;
                    if (wen) begin
                        sram_wen                   = 1'b1;
                        sram_wdata.dirty           = 1'b1;
                        sram_wdata.data[req_word]  = merged_word;
                        sram_wmask.dirty           = 1'b0;
                        sram_wmask.data[req_word]  = '0;
                    end
                end else if (req) begin
                    if (sram_rdata.valid && sram_rdata.dirty) begin
                        blk_addr_n = {sram_rdata.tag, req_set,
                                      {(cache_pkg::WORD_SEL_BITS + 2){1'b0}}};
                        next_state = cache_pkg::WRITEBACK;
                    end else begin
                        blk_addr_n = {addr[cache_pkg::WORD_BITS-1:cache_pkg::WORD_SEL_BITS+2],
                                      {(cache_pkg::WORD_SEL_BITS + 2){1'b0}}};
                        next_state = cache_pkg::FETCH;
                    end
                end
            end
            cache_pkg::WRITEBACK: begin
                mem_wen   = 1'b1;
                mem_addr  = xfer_addr;
                mem_wdata = sram_rdata.data[word_num];
                if (!mem_busy) begin
                    word_en = 1'b1;
                    if (word_last) begin
                        word_clr   = 1'b1;
                        blk_addr_n = {addr[cache_pkg::WORD_BITS-1:cache_pkg::WORD_SEL_BITS+2],
                                      {(cache_pkg::WORD_SEL_BITS + 2){1'b0}}};
                        next_state = cache_pkg::FETCH;
                    end
                end
            end
            cache_pkg::FETCH: begin
                mem_ren  = 1'b1;
                mem_addr = xfer_addr;
                if (!mem_busy) begin
                    sram_wen                  = 1'b1;
                    word_en                   = 1'b1;
                    sram_wdata.data[word_num] = mem_rdata;
                    sram_wmask.data[word_num] = '0;
                    if (word_last) begin  // tag and valid with the last word, dirty cleared
                        word_clr         = 1'b1;
                        sram_wdata.valid = 1'b1;
                        sram_wdata.tag   = blk_addr[cache_pkg::WORD_BITS-1 -: cache_pkg::TAG_BITS];
                        sram_wmask.valid = 1'b0;
                        sram_wmask.dirty = 1'b0;
                        sram_wmask.tag   = '0;
                        next_state       = cache_pkg::READY;
                    end
                end
            end
            cache_pkg::FLUSH: begin
                if (flush_finish) begin
                    flush_clr  = 1'b1;
                    flush_done = 1'b1;
                    next_state = cache_pkg::READY;
                end else if (!rd_ok) begin
                    rd_ok_n = 1'b1;
                end else if (sram_rdata.valid && sram_rdata.dirty) begin
                    mem_wen   = 1'b1;
                    mem_addr  = {sram_rdata.tag, flush_set, flush_word, 2'b00};
                    mem_wdata = sram_rdata.data[flush_word];
                    if (!mem_busy) begin
                        flush_step_word = 1'b1;
                        if (flush_last) begin
                            sram_wen   = 1'b1;
                            sram_wmask = '0;
                            rd_ok_n    = 1'b0;  // moving to next set
                        end
                    end
                end else begin
                    sram_wen       = 1'b1;  // clean or invalid, just clear
                    sram_wmask     = '0;
                    flush_step_set = 1'b1;
                    rd_ok_n        = 1'b0;
                end
            end
            default: next_state = cache_pkg::READY;
        endcase
    end

    a_one_strobe: assert property (
        @(posedge CLK) disable iff (!nRST)
        !(mem_ren && mem_wen)
    );

endmodule

// ==== source/l1_cache.sv ====
// write-back, write-allocate direct-mapped L1; request and memory access held until busy falls
`timescale 1ns/100ps

module l1_cache (
    input  logic             CLK,
    input  logic             nRST,
    input  cache_pkg::word_t addr,
    input  cache_pkg::word_t wdata,
    input  logic             ren,
    input  logic             wen,
    input  logic [3:0]       byte_en,
    output cache_pkg::word_t rdata,
    output logic             busy,
    output cache_pkg::word_t mem_addr,
    output cache_pkg::word_t mem_wdata,
    output logic             mem_ren,
    output logic             mem_wen,
    output logic [3:0]       mem_byte_en,
    input  cache_pkg::word_t mem_rdata,
    input  logic             mem_busy,
    input  logic             flush,
    output logic             flush_done
);

    // array
    cache_pkg::set_idx_t  sram_sel;
    logic                 sram_wen;
    cache_pkg::frame_t    sram_wdata, sram_wmask, sram_rdata;
    // lookup results
    logic                 hit, noncache;
    cache_pkg::set_idx_t  req_set;
    cache_pkg::word_sel_t req_word;
    cache_pkg::word_t     hit_word, merged_word, lane_word;
    // counters
    logic                 word_en, word_clr, flush_step_word, flush_step_set, flush_clr;
    cache_pkg::word_sel_t word_num, flush_word;
    cache_pkg::set_idx_t  flush_set;
    logic                 flush_finish;

    cache_sram u_sram (
        .CLK, .nRST, .sel(sram_sel), .wen(sram_wen),
        .wdata(sram_wdata), .wmask(sram_wmask), .rdata(sram_rdata)
    );

    cache_lookup u_lookup (
        .addr, .wdata, .byte_en, .frame(sram_rdata),
        .hit, .noncache, .req_set, .req_word,
        .hit_word, .merged_word, .lane_word
    );

    cache_counters u_counters (
        .CLK, .nRST, .word_en, .word_clr, .flush_step_word, .flush_step_set, .flush_clr,
        .word_num, .flush_set, .flush_word, .flush_finish
    );

    cache_controller u_ctrl (
        .CLK, .nRST, .ren, .wen, .flush, .addr, .wdata, .byte_en,
        .hit, .noncache, .req_set, .req_word, .hit_word, .merged_word, .lane_word,
        .sram_rdata, .mem_rdata, .mem_busy,
        .word_num, .flush_set, .flush_word, .flush_finish,
        .sram_sel, .sram_wen, .sram_wdata, .sram_wmask,
        .word_en, .word_clr, .flush_step_word, .flush_step_set, .flush_clr,
        .mem_addr, .mem_wdata, .mem_ren, .mem_wen, .mem_byte_en,
        .rdata, .busy, .flush_done
    );

endmodule

// ==== bench/mem_model.sv ====
// fixed two-cycle busy per access; 256 words decoded from addr[9:2], higher address bits ignored
`timescale 1ns/100ps

module mem_model (
    input  logic        CLK,
    input  logic        nRST,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    input  logic        ren,
    input  logic        wen,
    input  logic [3:0]  byte_en,
    output logic [31:0] rdata,
    output logic        busy
);

    localparam int WAIT_CYCLES = 2;

    logic [31:0] mem [256];
    logic [1:0]  wait_cnt;
    logic [7:0]  idx;

    assign idx   = addr[9:2];
    assign busy  = (ren || wen) && (wait_cnt != WAIT_CYCLES);
    assign rdata = mem[idx];  // valid once busy drops

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'h9E37_79B9 * (i + 1);  // differs in every index bit
        end
    end

    always @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wait_cnt <= '0;
        end else if (!(ren || wen) || !busy) begin
            wait_cnt <= '0;  // idle, or access done at this edge
        end else begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    // write lands at the edge that ends the access
    always @(posedge CLK) begin
        if (wen && !busy) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) begin
                    mem[idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

// ==== bench/l1_cache_tb.sv ====
// cacheable test addresses stay below 0x200, pass-through ones start at F000_0200
`timescale 1ns/100ps

module l1_cache_tb;

    localparam int          SEED_INIT      = 7;
    localparam int          RANDOM_OPS     = 160;
    localparam int          PARTIAL_OPS    = 40;
    localparam int          PASS_OPS       = 8;
    localparam logic [31:0] NC_BOUNDARY    = 32'hF000_0000;
    localparam logic [31:0] NC_BASE        = 32'hF000_0200;
    // about 300 requests at 12 miss cycles each, plus the sweep and two flushes
    localparam int          TIMEOUT_CYCLES = 6000;

    logic        CLK = 1'b0;
    logic        nRST;
    logic [31:0] addr, wdata, rdata;
    logic        ren, wen, busy;
    logic [3:0]  byte_en;
    logic [31:0] mem_addr, mem_wdata, mem_rdata;
    logic        mem_ren, mem_wen, mem_busy;
    logic [3:0]  mem_byte_en;
    logic        flush, flush_done;

    logic [31:0] shadow [256];  // what memory must hold once the cache is flushed
    integer      seed = SEED_INIT;
    int          checks = 0;
    int          errors = 0;
    int          cycle_count = 0;
    int          done_count = 0;
    int          done_start;
    string       test_name = "idle";

    l1_cache DUT (.*);

    mem_model u_mem (
        .CLK, .nRST, .addr(mem_addr), .wdata(mem_wdata), .ren(mem_ren), .wen(mem_wen),
        .byte_en(mem_byte_en), .rdata(mem_rdata), .busy(mem_busy)
    );

    always #10 CLK = ~CLK;

    // reference: last processor write, else the memory's own word
    function automatic logic [31:0] expected_word(input logic [31:0] a);
        return shadow[a[9:2]];
    endfunction

    function automatic logic [31:0] merge_lanes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  lanes);
        logic [31:0] result;
        result = old_word;
        for (int i = 0; i < 4; i++) begin
            if (lanes[i]) result[8*i +: 8] = new_word[8*i +: 8];
        end
        return result;
    endfunction

    // tag 0..3, set and word from the low random bits
    function automatic logic [31:0] block_addr(input logic [31:0] r);
        return {23'd0, r[6:0], 2'b00};
    endfunction

    function automatic logic [3:0] lane_pattern(input int k);
        case (k % 5)
            0:       return 4'b0001;
            1:       return 4'b0010;
            2:       return 4'b1100;
            3:       return 4'b0011;
            default: return 4'b1111;
        endcase
    endfunction

    task automatic compare_word(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_sweep_bus(input int cycles);
        repeat (cycles) begin
            @(negedge CLK);
            compare_word("sweep busy", 32'd1, busy);
            compare_word("sweep mem_ren", 32'd0, mem_ren);
            compare_word("sweep mem_wen", 32'd0, mem_wen);
            compare_word("sweep flush_done", 32'd0, flush_done);
        end
    endtask

    task automatic finish_request();
        @(negedge CLK);
        while (busy) @(negedge CLK);
        @(posedge CLK);
        #2;
        ren = 1'b0;
        wen = 1'b0;
    endtask

    task automatic access(input string name, input logic wr, input logic [31:0] a,
                          input logic [31:0] d, input logic [3:0] lanes);
        test_name = name;
        addr      = a;
        wdata     = d;
        byte_en   = lanes;
        ren       = !wr;
        wen       = wr;
        finish_request();
    endtask

    task automatic run_flush(input string name);
        test_name  = name;
        done_start = done_count;
        flush      = 1'b1;
        @(posedge CLK);
        #2;
        flush = 1'b0;
        @(negedge CLK);
        while (!flush_done) begin
            compare_word(name, 32'd1, busy);  // busy for the whole flush
            @(negedge CLK);
        end
        repeat (4) @(posedge CLK);
        compare_word(name, 32'd1, done_count - done_start);
        for (int i = 0; i < 256; i++) begin
            compare_word(name, shadow[i], u_mem.mem[i]);
        end
    endtask

    // comparing process, also keeps the shadow memory
    always @(negedge CLK) begin
        if (nRST && !busy && ren && !wen) begin
            compare_word(test_name, expected_word(addr), rdata);
        end
        if (nRST && !busy && wen) begin
            shadow[addr[9:2]] = merge_lanes(shadow[addr[9:2]], wdata, byte_en);
        end
        if (nRST && (ren || wen) && addr >= NC_BOUNDARY) begin
            compare_word(test_name, addr, mem_addr);
            compare_word(test_name, wen, mem_wen);
            compare_word(test_name, ren, mem_ren);
            if (wen) begin
                compare_word(test_name, merge_lanes(32'h0, wdata, byte_en), mem_wdata);
                compare_word(test_name, byte_en, mem_byte_en);
            end
        end
        if (flush_done) done_count++;
    end

    always @(posedge CLK) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        logic [31:0] r;
        logic [31:0] d;
        nRST    = 1'b0;
        addr    = '0;
        wdata   = '0;
        ren     = 1'b0;
        wen     = 1'b0;
        byte_en = 4'hF;
        flush   = 1'b0;
        repeat (3) @(posedge CLK);
        for (int i = 0; i < 256; i++) begin
            shadow[i] = u_mem.mem[i];
        end
        #2;
        nRST = 1'b1;

        // first read arrives during the sweep and has to wait it out
        test_name = "after reset";
        addr      = 32'h0000_0044;
        ren       = 1'b1;
        check_sweep_bus(cache_pkg::N_SETS + 1);
        finish_request();

        for (int i = 0; i < RANDOM_OPS; i++) begin
            r = $random(seed);
            d = $random(seed);
            access("read after write", r[12], block_addr(r), d, 4'hF);
        end
        run_flush("flush 1");

        for (int i = 0; i < PARTIAL_OPS; i++) begin
            r = $random(seed);
            d = $random(seed);
            access("partial write", 1'b1, block_addr(r), d, lane_pattern(i));
            access("partial write", 1'b0, block_addr(r), 32'h0, 4'hF);
        end

        for (int i = 0; i < PASS_OPS; i++) begin
            r = $random(seed);
            d = $random(seed);
            access("pass-through", 1'b1, NC_BASE + 4 * i, d, lane_pattern(r[2:0]));
            access("pass-through", 1'b0, NC_BASE + 4 * i, 32'h0, 4'hF);
        end
        run_flush("flush 2");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== l1_cache.f ====
source/cache_pkg.sv
source/cache_sram.sv
source/cache_lookup.sv
source/cache_counters.sv
source/cache_controller.sv
source/l1_cache.sv
bench/mem_model.sv
bench/l1_cache_tb.sv
